//--- rtl/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// data word width in bits
`define WORD_SIZE 16

// word address width, covers the whole 256-word memory
`define ADDR_SIZE 8

// words per cache line
`define LINE_WORDS 4

// lines per cache, direct mapped
`define LINE_NUMBER 8

// cycles from an accepted memory request to its done pulse
`define MEM_LATENCY 4

`endif

//--- rtl/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

	localparam int OFFSET_W = $clog2(`LINE_WORDS);
	localparam int INDEX_W = $clog2(`LINE_NUMBER);
	localparam int TAG_W = `ADDR_SIZE - INDEX_W - OFFSET_W;

	typedef logic [`WORD_SIZE-1:0] word_t;

	// cpu word address split into its cache fields
	typedef struct packed {
		logic [TAG_W-1:0] tag;
		logic [INDEX_W-1:0] index;
		logic [OFFSET_W-1:0] offset;
	} cache_addr_t;

	typedef word_t [`LINE_WORDS-1:0] line_t;

	// tag and index, the address of a whole line
	typedef logic [TAG_W+INDEX_W-1:0] line_addr_t;

	// valid is a level, held until done
	typedef struct packed {
		logic valid;
		logic write;
		line_addr_t addr;
		line_t wline;
	} mem_req_t;

	typedef struct packed {
		logic done;
		line_t rline;
	} mem_rsp_t;

endpackage

`default_nettype wire

//--- rtl/icache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module icache
	import cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_read,
	input wire cache_addr_t i_addr,
	input wire mem_rsp_t i_mem_rsp,
	output word_t o_data,
	output logic o_busy,
	output mem_req_t o_mem_req
);

	line_t data_arr [`LINE_NUMBER];
	logic [TAG_W-1:0] tag_arr [`LINE_NUMBER];
	logic [`LINE_NUMBER-1:0] valid_arr;
	logic filling;
	logic hit;
	logic rd_hit;
	logic fill_done;

	assign hit = valid_arr[i_addr.index] && (tag_arr[i_addr.index] == i_addr.tag);
	assign rd_hit = !filling && i_read && hit;
	assign fill_done = filling && i_mem_rsp.done;
	assign o_busy = filling;

	// read-only client, the line address comes from the held cpu address
	always_comb begin
		o_mem_req.valid = filling;
		o_mem_req.write = 1'b0;
		o_mem_req.addr = {i_addr.tag, i_addr.index};
		o_mem_req.wline = '0;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			filling <= 1'b0;
			valid_arr <= '0;
		end else if (filling) begin
			if (fill_done) begin
				filling <= 1'b0;
				valid_arr[i_addr.index] <= 1'b1;
			end
		end else if (i_read && !hit) begin
			filling <= 1'b1;
		end
	end

	// line install on done, word fetch on a hit
	always_ff @(posedge clk) begin
		if (fill_done) begin
			data_arr[i_addr.index] <= i_mem_rsp.rline;
			tag_arr[i_addr.index] <= i_addr.tag;
		end
		if (rd_hit) begin
			o_data <= data_arr[i_addr.index][i_addr.offset];
		end
	end

endmodule

`default_nettype wire

//--- rtl/dcache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module dcache
	import cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_read,
	input wire logic i_write,
	input wire cache_addr_t i_addr,
	input wire word_t i_wdata,
	input wire mem_rsp_t i_mem_rsp,
	output word_t o_rdata,
	output logic o_busy,
	output mem_req_t o_mem_req
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_WB,
		S_FILL
	} state_t;

	state_t state;
	line_t data_arr [`LINE_NUMBER];
	logic [TAG_W-1:0] tag_arr [`LINE_NUMBER];
	logic [`LINE_NUMBER-1:0] valid_arr;
	logic [`LINE_NUMBER-1:0] dirty_arr;
	logic [INDEX_W-1:0] idx;
	logic hit;
	logic access;
	logic rd_hit;
	logic wr_hit;
	logic fill_done;

	assign idx = i_addr.index;
	assign hit = valid_arr[idx] && (tag_arr[idx] == i_addr.tag);
	assign access = (state == S_IDLE) && (i_read || i_write);
	assign rd_hit = access && i_read && hit;
	assign wr_hit = access && i_write && hit;
	assign fill_done = (state == S_FILL) && i_mem_rsp.done;
	assign o_busy = (state != S_IDLE);

	always_comb begin
		o_mem_req.valid = (state != S_IDLE);
		o_mem_req.write = (state == S_WB);
		// the victim goes back under its own tag
		if (state == S_WB) begin
			o_mem_req.addr = {tag_arr[idx], idx};
		end else begin
			o_mem_req.addr = {i_addr.tag, idx};
		end
		o_mem_req.wline = data_arr[idx];
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= S_IDLE;
			valid_arr <= '0;
			dirty_arr <= '0;
		end else begin
			case (state)
				S_IDLE: begin
					if (wr_hit) begin
						dirty_arr[idx] <= 1'b1;
					end else if (access && !hit) begin
						// a clean or empty victim is simply overwritten
						if (valid_arr[idx] && dirty_arr[idx]) begin
							state <= S_WB;
						end else begin
							state <= S_FILL;
						end
					end
				end
				S_WB: begin
					if (i_mem_rsp.done) begin
						dirty_arr[idx] <= 1'b0;
						state <= S_FILL;
					end
				end
				S_FILL: begin
					if (fill_done) begin
						valid_arr[idx] <= 1'b1;
						dirty_arr[idx] <= 1'b0;
						state <= S_IDLE;
					end
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (fill_done) begin
			data_arr[idx] <= i_mem_rsp.rline;
			tag_arr[idx] <= i_addr.tag;
		end else if (wr_hit) begin
			data_arr[idx][i_addr.offset] <= i_wdata;
		end
		if (rd_hit) begin
			o_rdata <= data_arr[idx][i_addr.offset];
		end
	end

endmodule

`default_nettype wire

//--- rtl/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
	import cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire mem_req_t i_ireq,
	input wire mem_req_t i_dreq,
	input wire mem_rsp_t i_mem_rsp,
	output mem_rsp_t o_irsp,
	output mem_rsp_t o_drsp,
	output mem_req_t o_mem_req
);

	logic granted;
	// owner_d set means the data cache holds the bus
	logic owner_d;
	logic last_d;
	logic cand_i;
	logic cand_d;
	logic pick_d;

	always_comb begin
		if (granted) begin
			// on done the grant can only pass to the other client
			cand_i = i_ireq.valid && owner_d && i_mem_rsp.done;
			cand_d = i_dreq.valid && !owner_d && i_mem_rsp.done;
		end else begin
			cand_i = i_ireq.valid;
			cand_d = i_dreq.valid;
		end
		pick_d = cand_d && (!cand_i || !last_d);
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			granted <= 1'b0;
			owner_d <= 1'b0;
			last_d <= 1'b1;
		end else if (!granted || i_mem_rsp.done) begin
			granted <= cand_i || cand_d;
			if (cand_i || cand_d) begin
				owner_d <= pick_d;
				last_d <= pick_d;
			end
		end
	end

	always_comb begin
		o_mem_req = '0;
		if (granted) begin
			o_mem_req = owner_d ? i_dreq : i_ireq;
		end
		o_irsp.rline = i_mem_rsp.rline;
		o_irsp.done = i_mem_rsp.done && granted && !owner_d;
		o_drsp.rline = i_mem_rsp.rline;
		o_drsp.done = i_mem_rsp.done && granted && owner_d;
	end

endmodule

`default_nettype wire

//--- rtl/main_memory.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module main_memory
	import cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire mem_req_t i_req,
	output mem_rsp_t o_rsp
);

	localparam int DEPTH = 2 ** `ADDR_SIZE;
	localparam int CNT_W = $clog2(`MEM_LATENCY + 1);

	word_t mem [DEPTH];
	logic busy;
	logic [CNT_W-1:0] cnt;
	logic done_q;
	line_t rline_q;
	logic req_write;
	line_addr_t req_addr;
	line_t req_wline;
	logic accept;
	logic expire;

	// the requester still holds valid during the done cycle
	assign accept = i_req.valid && !busy && !done_q;
	assign expire = busy && (cnt == '0);

	always_comb begin
		o_rsp.done = done_q;
		o_rsp.rline = rline_q;
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			busy <= 1'b0;
			cnt <= '0;
			done_q <= 1'b0;
		end else begin
			done_q <= expire;
			if (accept) begin
				busy <= 1'b1;
				cnt <= CNT_W'(`MEM_LATENCY - 1);
			end else if (expire) begin
				busy <= 1'b0;
			end else if (busy) begin
				cnt <= cnt - 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			req_write <= i_req.write;
			req_addr <= i_req.addr;
			req_wline <= i_req.wline;
		end
		// one word per line slot
		if (expire) begin
			for (int w = 0; w < `LINE_WORDS; w++) begin
				if (req_write) begin
					mem[{req_addr, OFFSET_W'(w)}] <= req_wline[w];
				end else begin
					rline_q[w] <= mem[{req_addr, OFFSET_W'(w)}];
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/split_cache_top.sv
`timescale 1ns/1ps
`default_nettype none

module split_cache_top
	import cache_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic i_read1,
	input wire cache_addr_t i_addr1,
	output word_t o_data1,
	output logic o_busy1,
	input wire logic i_read2,
	input wire logic i_write2,
	input wire cache_addr_t i_addr2,
	input wire word_t i_wdata2,
	output word_t o_rdata2,
	output logic o_busy2
);

	mem_req_t ireq;
	mem_req_t dreq;
	mem_req_t mreq;
	mem_rsp_t irsp;
	mem_rsp_t drsp;
	mem_rsp_t mrsp;

	// instruction side, read only
	icache icache_inst (
		.clk(clk),
		.reset_n(reset_n),
		.i_read(i_read1),
		.i_addr(i_addr1),
		.i_mem_rsp(irsp),
		.o_data(o_data1),
		.o_busy(o_busy1),
		.o_mem_req(ireq)
	);

	dcache dcache_inst (
		.clk(clk),
		.reset_n(reset_n),
		.i_read(i_read2),
		.i_write(i_write2),
		.i_addr(i_addr2),
		.i_wdata(i_wdata2),
		.i_mem_rsp(drsp),
		.o_rdata(o_rdata2),
		.o_busy(o_busy2),
		.o_mem_req(dreq)
	);

	mem_arbiter mem_arbiter_inst (
		.clk(clk),
		.reset_n(reset_n),
		.i_ireq(ireq),
		.i_dreq(dreq),
		.i_mem_rsp(mrsp),
		.o_irsp(irsp),
		.o_drsp(drsp),
		.o_mem_req(mreq)
	);

	main_memory main_memory_inst (
		.clk(clk),
		.reset_n(reset_n),
		.i_req(mreq),
		.o_rsp(mrsp)
	);

endmodule

`default_nettype wire

//--- sim/tb_split_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_split_cache
	import cache_pkg::*;
();

	localparam int NUM_ACCESSES = 50;
	localparam int CYCLES_PER_ACCESS = 40;
	localparam int BUSY_LIMIT = 40;

	logic clk;
	logic reset_n;
	logic i_read1;
	cache_addr_t i_addr1;
	word_t o_data1;
	logic o_busy1;
	logic i_read2;
	logic i_write2;
	cache_addr_t i_addr2;
	word_t i_wdata2;
	word_t o_rdata2;
	logic o_busy2;

	integer seed;
	int checks;
	int errors;
	int tests;
	int start_checks;
	int start_errors;

	// data port view of memory and the words that have reached main memory
	word_t data_model [int];
	word_t mem_model [int];
	// data cache tags as the eviction rule predicts them
	logic [TAG_W-1:0] shadow_tag [`LINE_NUMBER];
	logic [`LINE_NUMBER-1:0] shadow_valid;
	logic [`LINE_NUMBER-1:0] shadow_dirty;

	string sig_q [$];
	word_t got_q [$];
	word_t exp_q [$];
	event check_ev;

	logic [7:0] first_addr;
	logic [7:0] line_a;
	logic [7:0] addr_b;

	split_cache_top split_cache_top_inst (
		.clk(clk),
		.reset_n(reset_n),
		.i_read1(i_read1),
		.i_addr1(i_addr1),
		.o_data1(o_data1),
		.o_busy1(o_busy1),
		.i_read2(i_read2),
		.i_write2(i_write2),
		.i_addr2(i_addr2),
		.i_wdata2(i_wdata2),
		.o_rdata2(o_rdata2),
		.o_busy2(o_busy2)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// the instruction port only sees what has been written back
	function automatic word_t expected_word(input logic port_d, input logic [7:0] a);
		if (port_d && data_model.exists(a)) begin
			return data_model[a];
		end else if (!port_d && mem_model.exists(a)) begin
			return mem_model[a];
		end
		return 'x;
	endfunction

	function automatic void track_access(input logic [7:0] a, input logic wr, input word_t d);
		cache_addr_t f;
		logic [7:0] la;
		f = a;
		if (shadow_valid[f.index] && shadow_tag[f.index] != f.tag) begin
			if (shadow_dirty[f.index]) begin
				for (int w = 0; w < `LINE_WORDS; w++) begin
					la = {shadow_tag[f.index], f.index, OFFSET_W'(w)};
					if (data_model.exists(la)) begin
						mem_model[la] = data_model[la];
					end
				end
			end
			shadow_valid[f.index] = 1'b0;
		end
		if (!shadow_valid[f.index]) begin
			shadow_valid[f.index] = 1'b1;
			shadow_tag[f.index] = f.tag;
			shadow_dirty[f.index] = 1'b0;
		end
		if (wr) begin
			shadow_dirty[f.index] = 1'b1;
			data_model[a] = d;
		end
	endfunction

	task automatic queue_check(input string sig, input word_t got, input word_t exp);
		sig_q.push_back(sig);
		got_q.push_back(got);
		exp_q.push_back(exp);
		-> check_ev;
	endtask

	initial begin
		string sig;
		word_t got;
		word_t exp;
		forever begin
			@(check_ev);
			while (sig_q.size() > 0) begin
				sig = sig_q.pop_front();
				got = got_q.pop_front();
				exp = exp_q.pop_front();
				checks++;
				assert (got === exp) else begin
					$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, sig, got, exp);
					errors++;
				end
			end
		end
	end

	// port_d high selects the data port and low the instruction port
	task automatic access(input logic port_d, input logic wr, input logic [7:0] a,
		input word_t d, output word_t q, output logic saw_busy);
		int waited;
		saw_busy = 1'b0;
		waited = 0;
		@(posedge clk);
		if (port_d) begin
			i_read2 <= !wr;
			i_write2 <= wr;
			i_addr2 <= a;
			i_wdata2 <= d;
		end else begin
			i_read1 <= 1'b1;
			i_addr1 <= a;
		end
		@(posedge clk);
		@(negedge clk);
		while ((port_d ? o_busy2 : o_busy1) && waited < BUSY_LIMIT) begin
			saw_busy = 1'b1;
			waited++;
			@(negedge clk);
		end
		assert (!(port_d ? o_busy2 : o_busy1)) else begin
			$display("access to address %h did not complete, busy stayed high", a);
			errors++;
		end
		// the held strobe hits on this edge after a miss and once more after a hit
		@(posedge clk);
		if (port_d) begin
			i_read2 <= 1'b0;
			i_write2 <= 1'b0;
		end else begin
			i_read1 <= 1'b0;
		end
		@(negedge clk);
		q = port_d ? o_rdata2 : o_data1;
	endtask

	task automatic write_word(input logic [7:0] a, input word_t d);
		word_t q;
		logic saw_busy;
		access(1'b1, 1'b1, a, d, q, saw_busy);
		track_access(a, 1'b1, d);
	endtask

	task automatic read_check(input logic port_d, input logic [7:0] a, output logic saw_busy);
		word_t q;
		access(port_d, 1'b0, a, '0, q, saw_busy);
		if (port_d) begin
			track_access(a, 1'b0, '0);
			queue_check($sformatf("o_rdata2 at %h", a), q, expected_word(1'b1, a));
		end else begin
			queue_check($sformatf("o_data1 at %h", a), q, expected_word(1'b0, a));
		end
	endtask

	task automatic finish_test(input string name);
		@(posedge clk);
		tests++;
		$display("test %0d %s: %0d checks, %0d failed", tests, name,
			checks - start_checks, errors - start_errors);
		start_checks = checks;
		start_errors = errors;
	endtask

	task automatic first_miss_test();
		word_t q;
		logic saw_busy;
		@(negedge clk);
		queue_check("o_busy1 after reset", word_t'(o_busy1), word_t'(1'b0));
		queue_check("o_busy2 after reset", word_t'(o_busy2), word_t'(1'b0));
		first_addr = 8'($random(seed));
		// memory is still undefined so the value waits for test 2 to write it
		access(1'b1, 1'b0, first_addr, '0, q, saw_busy);
		track_access(first_addr, 1'b0, '0);
		queue_check("o_busy2 on first read", word_t'(saw_busy), word_t'(1'b1));
		finish_test("reset and first miss");
	endtask

	task automatic write_read_test();
		logic [7:0] addrs [16];
		int order [16];
		int j;
		int tmp;
		logic saw_busy;
		addrs[0] = first_addr;
		for (int i = 1; i < 16; i++) begin
			addrs[i] = 8'($random(seed));
		end
		for (int i = 0; i < 16; i++) begin
			order[i] = i;
			write_word(addrs[i], word_t'($random(seed)));
		end
		for (int i = 15; i > 0; i--) begin
			j = {$random(seed)} % (i + 1);
			tmp = order[i];
			order[i] = order[j];
			order[j] = tmp;
		end
		for (int i = 0; i < 16; i++) begin
			read_check(1'b1, addrs[order[i]], saw_busy);
		end
		finish_test("write then read");
	endtask

	task automatic eviction_test();
		logic [INDEX_W-1:0] idx;
		logic [TAG_W-1:0] tag_a;
		logic saw_busy;
		idx = INDEX_W'($random(seed));
		tag_a = TAG_W'($random(seed));
		line_a = {tag_a, idx, OFFSET_W'(0)};
		addr_b = {tag_a ^ TAG_W'(5), idx, OFFSET_W'($random(seed))};
		for (int w = 0; w < `LINE_WORDS; w++) begin
			write_word(line_a + 8'(w), word_t'($random(seed)));
		end
		// same index under another tag pushes line a out to memory
		write_word(addr_b, word_t'($random(seed)));
		for (int w = 0; w < `LINE_WORDS; w++) begin
			read_check(1'b1, line_a + 8'(w), saw_busy);
		end
		for (int w = 0; w < `LINE_WORDS; w++) begin
			read_check(1'b0, line_a + 8'(w), saw_busy);
		end
		finish_test("dirty eviction");
	endtask

	task automatic repeat_hit_test();
		logic saw_busy;
		read_check(1'b1, line_a, saw_busy);
		queue_check("o_busy2 on repeated line", word_t'(saw_busy), word_t'(1'b0));
		read_check(1'b0, line_a + 8'd1, saw_busy);
		queue_check("o_busy1 on repeated line", word_t'(saw_busy), word_t'(1'b0));
		finish_test("hit without busy");
	endtask

	task automatic concurrent_miss_test();
		logic busy_d;
		logic busy_i;
		fork
			read_check(1'b1, addr_b, busy_d);
			read_check(1'b0, addr_b, busy_i);
		join
		queue_check("o_busy2 on concurrent miss", word_t'(busy_d), word_t'(1'b1));
		queue_check("o_busy1 on concurrent miss", word_t'(busy_i), word_t'(1'b1));
		finish_test("concurrent misses");
	endtask

	initial begin
		seed = 37746;
		reset_n = 1'b0;
		i_read1 = 1'b0;
		i_addr1 = '0;
		i_read2 = 1'b0;
		i_write2 = 1'b0;
		i_addr2 = '0;
		i_wdata2 = '0;
		shadow_valid = '0;
		shadow_dirty = '0;
		repeat (3) @(posedge clk);
		reset_n <= 1'b1;
		first_miss_test();
		write_read_test();
		eviction_test();
		repeat_hit_test();
		concurrent_miss_test();
		$display("%0d tests, %0d checks, %0d failed", tests, checks, errors);
		if (errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

	initial begin
		repeat (NUM_ACCESSES * CYCLES_PER_ACCESS) @(posedge clk);
		$display("watchdog expired after %0d cycles, the run did not complete",
			NUM_ACCESSES * CYCLES_PER_ACCESS);
		$display("Errors found");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/icache.sv
rtl/dcache.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/split_cache_top.sv
sim/tb_split_cache.sv

//--- Bender.yml
package:
  name: split_cache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cache_pkg.sv
      - rtl/icache.sv
      - rtl/dcache.sv
      - rtl/mem_arbiter.sv
      - rtl/main_memory.sv
      - rtl/split_cache_top.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - sim/tb_split_cache.sv
